// ==== hdl/psram_ctrl_top.sv ====
/*
 * Wishbone classic to quad-SPI PSRAM bridge, 16 MiB device.
 * Pads are plain ports, tristate buffers live outside this block.
 */
module psram_ctrl_top #(
    parameter int ADDR_W       = psram_pkg::ADDR_W_DEF,
    parameter int DUMMY_CYCLES = psram_pkg::DUMMY_DEF
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    input  logic [3:0]  sel_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    output logic        ack_o,
    input  logic        we_i,
    output logic        sck_o,
    output logic        ce_n_o,
    input  logic [3:0]  din_i,
    output logic [3:0]  dout_o,
    output logic [3:0]  douten_o
);

    logic init_active;
    logic init_done;

    psram_req_if #(.ADDR_W(ADDR_W)) u_req_if ();
    qspi_pins_if u_pins_if ();

    psram_wb_decode #(
        .ADDR_W (ADDR_W)
    ) u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .adr_i        (adr_i),
        .dat_i        (dat_i),
        .sel_i        (sel_i),
        .cyc_i        (cyc_i),
        .stb_i        (stb_i),
        .we_i         (we_i),
        .dat_o        (dat_o),
        .ack_o        (ack_o),
        .init_start_o (init_active),
        .init_done_i  (init_done),
        .req          (u_req_if.master)
    );

    psram_init_seq u_init (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (init_active),
        .done_o  (init_done),
        .pins    (u_pins_if.driver)
    );

    psram_qspi_engine #(
        .ADDR_W       (ADDR_W),
        .DUMMY_CYCLES (DUMMY_CYCLES)
    ) u_engine (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req           (u_req_if.slave),
        .init_pins     (u_pins_if.monitor),
        .init_active_i (init_active),
        .sck_o         (sck_o),
        .ce_n_o        (ce_n_o),
        .dout_o        (dout_o),
        .douten_o      (douten_o),
        .din_i         (din_i)
    );

endmodule

// ==== hdl/psram_if.sv ====
/*
 * Request channel between the bus front end and the QSPI engine,
 * and the pad bundle of the init sequencer.
 */
interface psram_req_if #(
    parameter int ADDR_W = psram_pkg::ADDR_W_DEF
);
    import psram_pkg::*;

    logic              req_valid;
    logic              we;
    logic [ADDR_W-1:0] addr;
    xfer_size_e        size;
    // First byte on the wire sits in bits 7:0
    logic [31:0]       wdata;
    logic              done;
    logic [31:0]       rdata;

    modport master (
        output req_valid, we, addr, size, wdata,
        input  done, rdata
    );

    modport slave (
        input  req_valid, we, addr, size, wdata,
        output done, rdata
    );
endinterface

interface qspi_pins_if;
    logic       sck;
    logic       ce_n;
    logic [3:0] dout;
    logic       oe;

    modport driver (
        output sck, ce_n, dout, oe
    );

    modport monitor (
        input  sck, ce_n, dout, oe
    );
endinterface

// ==== hdl/psram_init_seq.sv ====
/*
 * Sends the enter-quad command once after reset, single-bit SPI on dout[0].
 * done_o stays high until the next reset.
 */
module psram_init_seq (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start_i,
    output logic done_o,
    qspi_pins_if.driver pins
);
    import psram_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEND,
        S_DONE
    } state_t;

    state_t     state;
    logic       sck_q;
    logic       ce_n_q;
    logic       oe_q;
    logic [2:0] bit_cnt;
    logic [7:0] cmd_sr;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state   <= S_IDLE;
            sck_q   <= 1'b0;
            ce_n_q  <= 1'b1;
            oe_q    <= 1'b0;
            bit_cnt <= 3'd0;
            cmd_sr  <= 8'h00;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state   <= S_SEND;
                        ce_n_q  <= 1'b0;
                        oe_q    <= 1'b1;
                        bit_cnt <= 3'd0;
                        cmd_sr  <= CMD_ENTER_QUAD;
                    end
                end
                S_SEND: begin
                    // Bit is set up while SCK is low, PSRAM samples on the rise
                    if (!sck_q) begin
                        sck_q <= 1'b1;
                    end else begin
                        sck_q  <= 1'b0;
                        cmd_sr <= {cmd_sr[6:0], 1'b0};
                        if (bit_cnt == 3'd7) begin
                            state  <= S_DONE;
                            ce_n_q <= 1'b1;
                            oe_q   <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    assign pins.sck  = sck_q;
    assign pins.ce_n = ce_n_q;
    assign pins.dout = {3'b000, cmd_sr[7]};
    assign pins.oe   = oe_q;
    assign done_o    = (state == S_DONE);

endmodule

// ==== hdl/psram_pkg.sv ====
/*
 * Shared constants for the quad-SPI PSRAM controller.
 * Command codes follow the common APS6404-style PSRAM command set.
 */
package psram_pkg;

    // PSRAM byte address width, 16 MiB
    localparam int ADDR_W_DEF = 24;

    // Wait cycles between address and first read nibble
    localparam int DUMMY_DEF = 6;

    // Sent serially on dout[0] right after reset
    localparam logic [7:0] CMD_ENTER_QUAD = 8'h35;

    // Quad fast read and quad write
    localparam logic [7:0] CMD_QUAD_READ  = 8'hEB;
    localparam logic [7:0] CMD_QUAD_WRITE = 8'h38;

    // Number of bytes moved by one transfer
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } xfer_size_e;

endpackage

// ==== hdl/psram_qspi_engine.sv ====
/*
 * Quad-SPI transfer engine, SCK runs at clk_i/2 with no divider.
 * 24-bit address phase always; no page-boundary split, no tCEM limit.
 */
module psram_qspi_engine #(
    parameter int ADDR_W       = psram_pkg::ADDR_W_DEF,
    parameter int DUMMY_CYCLES = psram_pkg::DUMMY_DEF
) (
    input  logic       clk_i,
    input  logic       rst_i,
    psram_req_if.slave req,
    qspi_pins_if.monitor init_pins,
    input  logic       init_active_i,
    output logic       sck_o,
    output logic       ce_n_o,
    output logic [3:0] dout_o,
    output logic [3:0] douten_o,
    input  logic [3:0] din_i
);
    import psram_pkg::*;

    // A read takes 2 command, 6 address, dummy and 8 data SCK periods
    localparam int HDR_SLOTS  = 8;
    localparam int DATA_START = HDR_SLOTS + DUMMY_CYCLES;
    localparam int RD_SLOTS   = DATA_START + 8;
    localparam int CNT_W      = $clog2(RD_SLOTS);

    logic             busy;
    logic             sck_q;
    logic             ce_n_q;
    logic             done_q;
    logic             is_wr;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] last;
    logic             accept;
    logic             drive_en;
    logic             rd_data_phase;
    logic [23:0]      addr24;
    logic [7:0]       cmd;
    logic [63:0]      tx_sr;
    logic [31:0]      rx_sr;

    assign accept = ~busy & req.req_valid;
    assign addr24 = 24'(req.addr);
    assign cmd    = req.we ? CMD_QUAD_WRITE : CMD_QUAD_READ;

    // Outputs are enabled for command, address and write data
    assign drive_en      = busy & (is_wr | (cnt < HDR_SLOTS));
    assign rd_data_phase = busy & ~is_wr & (cnt >= DATA_START);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            busy   <= 1'b0;
            sck_q  <= 1'b0;
            ce_n_q <= 1'b1;
            done_q <= 1'b0;
            is_wr  <= 1'b0;
            cnt    <= '0;
            last   <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy   <= 1'b1;
                ce_n_q <= 1'b0;
                sck_q  <= 1'b0;
                is_wr  <= req.we;
                cnt    <= '0;
                if (!req.we) begin
                    last <= CNT_W'(RD_SLOTS - 1);
                end else begin
                    // Two nibbles per byte after the header
                    case (req.size)
                        SIZE_BYTE: last <= CNT_W'(HDR_SLOTS + 1);
                        SIZE_HALF: last <= CNT_W'(HDR_SLOTS + 3);
                        default:   last <= CNT_W'(HDR_SLOTS + 7);
                    endcase
                end
            end else if (busy) begin
                if (!sck_q) begin
                    sck_q <= 1'b1;
                end else begin
                    sck_q <= 1'b0;
                    if (cnt == last) begin
                        busy   <= 1'b0;
                        ce_n_q <= 1'b1;
                        done_q <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Wire order is the high nibble of each byte first
    always_ff @(posedge clk_i) begin
        if (accept) begin
            tx_sr <= {cmd, addr24, req.wdata[7:0], req.wdata[15:8],
                      req.wdata[23:16], req.wdata[31:24]};
        end else if (busy && sck_q) begin
            tx_sr <= {tx_sr[59:0], 4'h0};
        end

        // Sampled on the clk edge that raises SCK
        if (rd_data_phase && !sck_q)
            rx_sr <= {rx_sr[27:0], din_i};
    end

    // First received byte lands in bits 7:0
    assign req.rdata = {rx_sr[7:0], rx_sr[15:8], rx_sr[23:16], rx_sr[31:24]};
    assign req.done  = done_q;

    // Init sequencer owns the pads until it is done
    assign sck_o    = init_active_i ? init_pins.sck      : sck_q;
    assign ce_n_o   = init_active_i ? init_pins.ce_n     : ce_n_q;
    assign dout_o   = init_active_i ? init_pins.dout     : (drive_en ? tx_sr[63:60] : 4'h0);
    assign douten_o = init_active_i ? {4{init_pins.oe}}  : {4{drive_en}};

    // Engine stays idle while the init sequencer drives the pads
    a_idle_in_init: assert property (@(posedge clk_i) disable iff (rst_i)
        init_active_i |-> !busy);

    // Front end must wait for done before the next request
    a_no_req_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        req.req_valid |-> !busy);

endmodule

// ==== hdl/psram_wb_decode.sv ====
/*
 * Wishbone classic slave front end. No bursts, no err/rty, one access at a time.
 * Bus is held off until the PSRAM init sequence has completed.
 */
module psram_wb_decode #(
    parameter int ADDR_W = psram_pkg::ADDR_W_DEF
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    input  logic [3:0]  sel_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    output logic        init_start_o,
    input  logic        init_done_i,
    psram_req_if.master req
);
    import psram_pkg::*;

    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t     state;
    logic       wb_valid;
    logic [1:0] lane_off;
    xfer_size_e size_d;
    logic [31:0] wdata_d;

    assign wb_valid = cyc_i & stb_i;

    // Any sel_i other than one lane or an aligned half-word is a full word
    always_comb begin
        lane_off = 2'd0;
        size_d   = SIZE_WORD;
        wdata_d  = dat_i;
        if (we_i) begin
            case (sel_i)
                4'b0001: begin
                    size_d  = SIZE_BYTE;
                    wdata_d = {24'h0, dat_i[7:0]};
                end
                4'b0010: begin
                    size_d   = SIZE_BYTE;
                    lane_off = 2'd1;
                    wdata_d  = {24'h0, dat_i[15:8]};
                end
                4'b0100: begin
                    size_d   = SIZE_BYTE;
                    lane_off = 2'd2;
                    wdata_d  = {24'h0, dat_i[23:16]};
                end
                4'b1000: begin
                    size_d   = SIZE_BYTE;
                    lane_off = 2'd3;
                    wdata_d  = {24'h0, dat_i[31:24]};
                end
                4'b0011: begin
                    size_d  = SIZE_HALF;
                    wdata_d = {16'h0, dat_i[15:0]};
                end
                4'b1100: begin
                    size_d   = SIZE_HALF;
                    lane_off = 2'd2;
                    wdata_d  = {16'h0, dat_i[31:16]};
                end
                default: begin
                    size_d = SIZE_WORD;
                end
            endcase
        end
    end

    // req_valid pulses for one cycle on leaving IDLE
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state         <= ST_INIT;
            req.req_valid <= 1'b0;
        end else begin
            req.req_valid <= 1'b0;
            case (state)
                ST_INIT: begin
                    if (init_done_i)
                        state <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (wb_valid) begin
                        state         <= ST_WAIT;
                        req.req_valid <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (req.done)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request payload is captured with the strobe
    always_ff @(posedge clk_i) begin
        if (state == ST_IDLE && wb_valid) begin
            req.we    <= we_i;
            req.addr  <= {adr_i[ADDR_W-1:2], lane_off};
            req.size  <= size_d;
            req.wdata <= wdata_d;
        end
    end

    assign init_start_o = (state == ST_INIT);
    assign ack_o        = (state == ST_WAIT) & req.done;
    assign dat_o        = req.rdata;

    // Master must keep the strobe up until the engine finishes
    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_o |-> (cyc_i && stb_i));

    // No request may reach the engine before the PSRAM is in quad mode
    a_req_after_init: assert property (@(posedge clk_i) disable iff (rst_i)
        req.req_valid |-> init_done_i);

endmodule

// ==== psram_ctrl.f ====
hdl/psram_pkg.sv
hdl/psram_if.sv
hdl/psram_wb_decode.sv
hdl/psram_init_seq.sv
hdl/psram_qspi_engine.sv
hdl/psram_ctrl_top.sv
verification/psram_model.sv
verification/tb_psram_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the PSRAM controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_psram_ctrl \
    -f psram_ctrl.f \
    -o sim_psram_ctrl

./obj_dir/sim_psram_ctrl > "$LOG" 2>&1
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

// ==== verification/psram_model.sv ====
/*
 * Behavioral quad-SPI PSRAM. Expects 35h in SPI mode before any quad command.
 * Bytes never written read back as a pattern of their full address.
 */
module psram_model #(
    parameter int DUMMY_CYCLES = psram_pkg::DUMMY_DEF
) (
    input  logic       sck_i,
    input  logic       ce_n_i,
    input  logic [3:0] dout_i,
    input  logic [3:0] oe_i,
    output logic [3:0] din_o,
    output logic       quad_o,
    output int         proto_err_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import psram_pkg::*;

    logic [7:0]  mem [logic [23:0]];
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [23:0] rd_addr;
    logic [3:0]  hi_nib;
    logic [7:0]  rd_byte;
    logic [3:0]  exp_oe;
    logic [3:0]  din_q = 4'h0;
    logic        quad_q = 1'b0;
    int          err_q = 0;
    int          n_rise = 0;
    int          nib_idx;

    assign din_o       = din_q;
    assign quad_o      = quad_q;
    assign proto_err_o = err_q;

    always @(posedge sck_i or posedge ce_n_i) begin
        if (ce_n_i) begin
            n_rise = 0;
        end else begin
            // Controller releases the pads for dummy and read data only
            exp_oe = (quad_q && cmd == CMD_QUAD_READ && n_rise >= 8) ? 4'h0 : 4'hF;
            assert (oe_i == exp_oe)
            else begin
                err_q++;
                $display("[FAIL] %0t douten_o: expected %h, got %h", $time, exp_oe, oe_i);
            end
            if (!quad_q) begin
                // One bit per rising edge on dout[0] in SPI mode
                cmd = {cmd[6:0], dout_i[0]};
                n_rise++;
                if (n_rise == 8) begin
                    assert (cmd == CMD_ENTER_QUAD)
                    else begin
                        err_q++;
                        $display("PSRAM model: command %h came before the enter-quad command",
                                 cmd);
                    end
                    quad_q = (cmd == CMD_ENTER_QUAD);
                end
            end else begin
                if (n_rise < 2) begin
                    cmd = {cmd[3:0], dout_i};
                end else if (n_rise < 8) begin
                    addr = {addr[19:0], dout_i};
                end else if (cmd == CMD_QUAD_WRITE) begin
                    if (n_rise[0] == 1'b0)
                        hi_nib = dout_i;
                    else
                        mem[addr + 24'((n_rise - 8) / 2)] = {hi_nib, dout_i};
                end else if (n_rise == 8) begin
                    assert (cmd == CMD_QUAD_READ)
                    else begin
                        err_q++;
                        $display("PSRAM model: unknown quad command %h", cmd);
                    end
                end
                n_rise++;
            end
        end
    end

    // Read nibbles change after the falling edge with the high nibble first
    always @(negedge sck_i) begin
        nib_idx = n_rise - 8 - DUMMY_CYCLES;
        if (!ce_n_i && quad_q && cmd == CMD_QUAD_READ && nib_idx >= 0 && nib_idx < 8) begin
            rd_addr = addr + 24'(nib_idx / 2);
            rd_byte = mem.exists(rd_addr) ? mem[rd_addr] :
                      (rd_addr[7:0] ^ rd_addr[15:8] ^ rd_addr[23:16] ^ 8'hA5);
            din_q <= nib_idx[0] ? rd_byte[3:0] : rd_byte[7:4];
        end
    end

endmodule

// ==== verification/tb_psram_ctrl.sv ====
/*
 * Testbench for the Wishbone PSRAM bridge against a behavioral PSRAM.
 * Random traffic stays inside a 64-byte window, with a fixed seed.
 */
module tb_psram_ctrl;
    timeunit 1ns;
    timeprecision 1ps;
    import psram_pkg::*;

    localparam int          WAIT_MAX = 400;
    localparam logic [23:0] WIN_BASE = 24'h012340;

    logic        clk_i;
    logic        rst_i;
    logic [31:0] adr_i;
    logic [31:0] dat_i;
    logic [31:0] dat_o;
    logic [3:0]  sel_i;
    logic        cyc_i;
    logic        stb_i;
    logic        we_i;
    logic        ack_o;
    logic        sck_o;
    logic        ce_n_o;
    logic [3:0]  din_i;
    logic [3:0]  dout_o;
    logic [3:0]  douten_o;
    logic        quad_seen;
    int          model_err;

    logic [7:0]  ref_mem [logic [23:0]];
    logic [31:0] exp_word;
    int          seed = 32'h1c74;
    int          chk_err = 0;
    int          seq_err = 0;
    int          timeouts = 0;
    int          ack_cnt = 0;

    psram_ctrl_top #(.ADDR_W(ADDR_W_DEF), .DUMMY_CYCLES(DUMMY_DEF)) u_dut (.*);

    psram_model #(.DUMMY_CYCLES(DUMMY_DEF)) u_model (
        .sck_i       (sck_o),
        .ce_n_i      (ce_n_o),
        .dout_i      (dout_o),
        .oe_i        (douten_o),
        .din_o       (din_i),
        .quad_o      (quad_seen),
        .proto_err_o (model_err)
    );

    function automatic logic [7:0] fill_byte(logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;
    endfunction

    // Single lanes and aligned half-words keep their lanes and all else is a word
    function automatic void apply_write(logic [23:0] a, logic [31:0] d, logic [3:0] sel);
        logic [3:0] lanes;
        case (sel)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100: lanes = sel;
            default: lanes = 4'b1111;
        endcase
        for (int i = 0; i < 4; i++)
            if (lanes[i])
                ref_mem[{a[23:2], 2'(i)}] = d[8*i +: 8];
    endfunction

    // Lowest address byte lands in bits 7:0
    function automatic logic [31:0] expected_word(logic [23:0] a);
        logic [31:0] w;
        logic [23:0] b;
        for (int i = 0; i < 4; i++) begin
            b = {a[23:2], 2'(i)};
            w[8*i +: 8] = ref_mem.exists(b) ? ref_mem[b] : fill_byte(b);
        end
        return w;
    endfunction

    task automatic bus_access(input logic wr, input logic [23:0] a, input logic [31:0] d,
                              input logic [3:0] sel);
        int waited;
        int acks_before;
        if (timeouts != 0)
            return;
        waited = 0;
        @(posedge clk_i);
        adr_i <= {8'h00, a};
        dat_i <= d;
        sel_i <= sel;
        we_i  <= wr;
        cyc_i <= 1'b1;
        stb_i <= 1'b1;
        acks_before = ack_cnt;
        if (wr)
            apply_write(a, d, sel);
        do begin
            @(posedge clk_i);
            waited++;
        end while (!ack_o && waited < WAIT_MAX);
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        if (!ack_o) begin
            timeouts++;
            $display("No ack_o within %0d cycles for the access at %h", WAIT_MAX, a);
        end else begin
            // A stretched ack would be counted on the next edge
            @(posedge clk_i);
            @(negedge clk_i);
            assert (ack_cnt == acks_before + 1)
            else begin
                seq_err++;
                $display("Access at %h got %0d acks instead of one", a, ack_cnt - acks_before);
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (ack_o) begin
            ack_cnt++;
            assert (cyc_i && stb_i)
            else begin
                chk_err++;
                $display("ack_o was raised at %0t without a held strobe", $time);
            end
            assert (quad_seen)
            else begin
                chk_err++;
                $display("ack_o was raised before the PSRAM got the enter-quad command");
            end
            if (!we_i) begin
                exp_word = expected_word(adr_i[23:0]);
                assert (dat_o == exp_word)
                else begin
                    chk_err++;
                    $display("[FAIL] %0t dat_o: expected %h, got %h", $time, exp_word, dat_o);
                end
            end
        end
    end

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        logic [23:0] a;
        logic [31:0] d;
        rst_i = 1'b1;
        adr_i = '0;
        dat_i = '0;
        sel_i = '0;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;

        // Strobe goes up while the init sequence is still running
        bus_access(1'b0, WIN_BASE, 32'h0, 4'hF);

        for (int i = 0; i < 4; i++)
            bus_access(1'b1, WIN_BASE + 24'(16 * i), $random(seed), 4'hF);
        for (int i = 0; i < 4; i++)
            bus_access(1'b0, WIN_BASE + 24'(16 * i), 32'h0, 4'hF);

        // One word merged from four single-lane writes
        for (int i = 0; i < 4; i++)
            bus_access(1'b1, WIN_BASE + 24'h4, $random(seed), 4'(1 << i));
        bus_access(1'b0, WIN_BASE + 24'h4, 32'h0, 4'hF);

        bus_access(1'b1, WIN_BASE + 24'h8, $random(seed), 4'b0011);
        bus_access(1'b1, WIN_BASE + 24'h8, $random(seed), 4'b1100);
        bus_access(1'b0, WIN_BASE + 24'h8, 32'h0, 4'hF);
        // Irregular lane pattern is written as a full word
        bus_access(1'b1, WIN_BASE + 24'hC, $random(seed), 4'b0110);
        bus_access(1'b0, WIN_BASE + 24'hC, 32'h0, 4'hF);

        for (int i = 0; i < 200; i++) begin
            a = WIN_BASE + 24'($random(seed) & 63);
            d = $random(seed);
            bus_access(1'($random(seed)), a, d, 4'($random(seed)));
        end

        repeat (4) @(posedge clk_i);
        assert (quad_seen)
        else begin
            seq_err++;
            $display("The enter-quad command never reached the PSRAM");
        end
        $display("Errors: checker %0d, sequence %0d, model %0d, timeouts %0d",
                 chk_err, seq_err, model_err, timeouts);
        if (chk_err + seq_err + model_err + timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
